// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4; // pc step

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B, // lui
        ALU_EQ,
        ALU_NE,
        ALU_LT,
        ALU_GE
    } alu_op_t;

endpackage

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t         op_i,
    input  logic [cpu_pkg::XLEN-1:0] a_i,
    input  logic [cpu_pkg::XLEN-1:0] b_i,
    input  logic [cpu_pkg::XLEN-1:0] imm_i,
    input  logic                     use_imm_i,
    output logic [cpu_pkg::XLEN-1:0] result_o,
    output logic                     branch_taken_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0] b;
    logic [4:0]      shamt;

    assign b     = use_imm_i ? imm_i : b_i;
    assign shamt = b[4:0]; // upper bits ignored for shifts

    always_comb begin
        result_o       = '0;
        branch_taken_o = 1'b0;
        case (op_i)
            ALU_ADD:    result_o = a_i + b;
            ALU_SUB:    result_o = a_i - b;
            ALU_XOR:    result_o = a_i ^ b;
            ALU_OR:     result_o = a_i | b;
            ALU_AND:    result_o = a_i & b;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_PASS_B: result_o = b;
            // branch compares, signed
            ALU_EQ:     branch_taken_o = (a_i == b);
            ALU_NE:     branch_taken_o = (a_i != b);
            ALU_LT:     branch_taken_o = ($signed(a_i) < $signed(b));
            ALU_GE:     branch_taken_o = ($signed(a_i) >= $signed(b));
            default:    result_o = '0;
        endcase
    end

endmodule

// ==== rtl/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  logic [cpu_pkg::XLEN-1:0]      instr_i,
    output logic [6:0]                    opcode_o,
    output logic [cpu_pkg::REG_IDX_W-1:0] rs1_o,
    output logic [cpu_pkg::REG_IDX_W-1:0] rs2_o,
    output logic [cpu_pkg::REG_IDX_W-1:0] rd_o,
    output logic [cpu_pkg::XLEN-1:0]      imm_o,
    output cpu_pkg::alu_op_t              alu_op_o,
    output logic                          use_imm_o
);
    import cpu_pkg::*;

    logic [6:0]      op;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i_fmt;
    logic [XLEN-1:0] imm_s_fmt;
    logic [XLEN-1:0] imm_b_fmt;
    logic [XLEN-1:0] imm_j_fmt;
    logic [XLEN-1:0] imm_u_fmt;
    logic            valid;

    assign op     = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // sign extended immediates, one per format
    assign imm_i_fmt = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s_fmt = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_fmt = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j_fmt = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};
    assign imm_u_fmt = {instr_i[31:12], 12'b0};

    always_comb begin
        valid     = 1'b1;
        opcode_o  = op;
        rs1_o     = instr_i[19:15];
        rs2_o     = instr_i[24:20];
        rd_o      = instr_i[11:7];
        imm_o     = '0;
        alu_op_o  = ALU_ADD;
        use_imm_o = 1'b0;
        case (op)
            OP_REG, OP_IMM: begin
                use_imm_o = (op == OP_IMM);
                imm_o     = imm_i_fmt;
                case (funct3)
                    3'b000:  alu_op_o = (op == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b100:  alu_op_o = ALU_XOR;
                    3'b110:  alu_op_o = ALU_OR;
                    3'b111:  alu_op_o = ALU_AND;
                    3'b001:  alu_op_o = ALU_SLL;
                    3'b101:  alu_op_o = ALU_SRL;
                    default: valid = 1'b0; // slt, sltu
                endcase
                // sra and unknown funct7 patterns are not supported
                if (op == OP_REG && funct7 != 7'b0000000 &&
                    !(funct3 == 3'b000 && funct7 == 7'b0100000)) begin
                    valid = 1'b0;
                end
                if (op == OP_IMM && (funct3 == 3'b001 || funct3 == 3'b101) &&
                    funct7 != 7'b0000000) begin
                    valid = 1'b0;
                end
            end
            OP_LUI: begin
                alu_op_o  = ALU_PASS_B;
                use_imm_o = 1'b1;
                imm_o     = imm_u_fmt;
            end
            OP_LOAD: begin
                use_imm_o = 1'b1;
                imm_o     = imm_i_fmt;
                valid     = (funct3 == 3'b010); // lw only
            end
            OP_STORE: begin
                use_imm_o = 1'b1;
                imm_o     = imm_s_fmt;
                rd_o      = '0;
                valid     = (funct3 == 3'b010); // sw only
            end
            OP_BRANCH: begin
                imm_o = imm_b_fmt; // pc offset, alu compares rs1 with rs2
                rd_o  = '0;
                case (funct3)
                    F3_BEQ:  alu_op_o = ALU_EQ;
                    F3_BNE:  alu_op_o = ALU_NE;
                    F3_BLT:  alu_op_o = ALU_LT;
                    F3_BGE:  alu_op_o = ALU_GE;
                    default: valid = 1'b0;
                endcase
            end
            OP_JAL: begin
                imm_o = imm_j_fmt;
            end
            default: valid = 1'b0;
        endcase
        // anything not understood becomes a nop
        if (!valid) begin
            opcode_o = '0;
            rd_o     = '0;
        end
    end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [cpu_pkg::REG_IDX_W-1:0] rs1_i,
    input  logic [cpu_pkg::REG_IDX_W-1:0] rs2_i,
    input  logic [cpu_pkg::REG_IDX_W-1:0] rd_i,
    input  logic                          we_i,
    input  logic [cpu_pkg::XLEN-1:0]      wd_i,
    output logic [cpu_pkg::XLEN-1:0]      rs1_data_o,
    output logic [cpu_pkg::XLEN-1:0]      rs2_data_o
);
    import cpu_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_en;

    // x0 and indices beyond the register set are never written
    assign wr_en = we_i && (rd_i != '0) && (int'(rd_i) < NUM_REGS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_i[IDX_W-1:0]] <= wd_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0 || int'(rs1_i) >= NUM_REGS) ? '0 : regs[rs1_i[IDX_W-1:0]];
    assign rs2_data_o = (rs2_i == '0 || int'(rs2_i) >= NUM_REGS) ? '0 : regs[rs2_i[IDX_W-1:0]];

endmodule

// ==== rtl/apb_master.sv ====
`timescale 1ns/1ps

module apb_master (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_i,
    input  logic                     we_i,
    input  logic [cpu_pkg::XLEN-1:0] addr_i,
    input  logic [cpu_pkg::XLEN-1:0] wdata_i,
    input  logic [cpu_pkg::XLEN-1:0] prdata_i,
    input  logic                     pready_i,
    output logic                     done_o,
    output logic [cpu_pkg::XLEN-1:0] rdata_o,
    output logic [cpu_pkg::XLEN-1:0] paddr_o,
    output logic                     psel_o,
    output logic                     penable_o,
    output logic                     pwrite_o,
    output logic [cpu_pkg::XLEN-1:0] pwdata_o
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } state_t;

    state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            pwrite_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_i) begin
                        state    <= SETUP;
                        pwrite_o <= we_i;
                    end
                end
                SETUP:   state <= ACCESS; // always exactly one cycle
                ACCESS: begin
                    if (pready_i) begin
                        state    <= IDLE;
                        pwrite_o <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address and write data captured on entry to setup, held through access
    always_ff @(posedge clk) begin
        if (state == IDLE && req_i) begin
            paddr_o  <= addr_i;
            pwdata_o <= wdata_i;
        end
    end

    assign psel_o    = (state != IDLE);
    assign penable_o = (state == ACCESS);
    assign done_o    = (state == ACCESS) && pready_i;
    assign rdata_o   = prdata_i; // valid in the done cycle

endmodule

// ==== rtl/fetch_sequencer.sv ====
`timescale 1ns/1ps

module fetch_sequencer #(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          bus_done_i,
    input  logic [cpu_pkg::XLEN-1:0]      bus_rdata_i,
    input  logic [cpu_pkg::XLEN-1:0]      alu_result_i,
    input  logic                          branch_taken_i,
    input  logic [cpu_pkg::XLEN-1:0]      imm_i,
    input  logic [cpu_pkg::XLEN-1:0]      rs2_data_i,
    input  logic [6:0]                    opcode_i,
    input  logic [cpu_pkg::REG_IDX_W-1:0] rd_i,
    output logic [cpu_pkg::XLEN-1:0]      instr_o,
    output logic                          bus_req_o,
    output logic                          bus_we_o,
    output logic [cpu_pkg::XLEN-1:0]      bus_addr_o,
    output logic [cpu_pkg::XLEN-1:0]      bus_wdata_o,
    output logic                          rd_we_o,
    output logic [cpu_pkg::XLEN-1:0]      rd_data_o
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEMORY
    } phase_t;

    phase_t          phase;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr_q;
    logic [XLEN-1:0] pc_next_seq;
    logic            is_load;
    logic            is_store;
    logic            writes_rd;
    logic            redirect;

    assign pc_next_seq = pc + INSTR_BYTES;
    assign is_load     = (opcode_i == OP_LOAD);
    assign is_store    = (opcode_i == OP_STORE);
    assign redirect    = (opcode_i == OP_JAL) || (opcode_i == OP_BRANCH && branch_taken_i);

    // x0 destinations never raise the write enable
    assign writes_rd = (opcode_i == OP_REG || opcode_i == OP_IMM ||
                        opcode_i == OP_LUI || opcode_i == OP_JAL) && (rd_i != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= FETCH;
            pc      <= RESET_PC;
            instr_q <= '0; // decodes as a nop
        end else begin
            case (phase)
                FETCH: begin
                    if (bus_done_i) begin
                        instr_q <= bus_rdata_i;
                        phase   <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (is_load || is_store) begin
                        phase <= MEMORY; // pc moves once the data transfer is done
                    end else begin
                        pc    <= redirect ? pc + imm_i : pc_next_seq;
                        phase <= FETCH;
                    end
                end
                MEMORY: begin
                    if (bus_done_i) begin
                        pc    <= pc_next_seq;
                        phase <= FETCH;
                    end
                end
                default: phase <= FETCH;
            endcase
        end
    end

    assign instr_o = instr_q;

    // request held for the whole of fetch and memory phases
    assign bus_req_o   = (phase == FETCH) || (phase == MEMORY);
    assign bus_we_o    = (phase == MEMORY) && is_store;
    assign bus_addr_o  = (phase == MEMORY) ? alu_result_i : pc;
    assign bus_wdata_o = rs2_data_i;

    assign rd_we_o = (phase == EXECUTE && writes_rd) ||
                     (phase == MEMORY && is_load && bus_done_i && rd_i != '0);

    always_comb begin
        if (is_load) begin
            rd_data_o = bus_rdata_i;
        end else if (opcode_i == OP_JAL) begin
            rd_data_o = pc_next_seq; // return address
        end else begin
            rd_data_o = alu_result_i;
        end
    end

endmodule

// ==== rtl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0,
    parameter int                       NUM_REGS = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [cpu_pkg::XLEN-1:0] prdata_i,
    input  logic                     pready_i,
    output logic [cpu_pkg::XLEN-1:0] paddr_o,
    output logic                     psel_o,
    output logic                     penable_o,
    output logic                     pwrite_o,
    output logic [cpu_pkg::XLEN-1:0] pwdata_o
);
    import cpu_pkg::*;

    logic [XLEN-1:0]      instr;
    logic [6:0]           opcode;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      imm;
    alu_op_t              alu_op;
    logic                 use_imm;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic [XLEN-1:0]      alu_result;
    logic                 branch_taken;
    logic                 rd_we;
    logic [XLEN-1:0]      rd_data;

    // internal request pair towards the bus
    logic            bus_req;
    logic            bus_we;
    logic [XLEN-1:0] bus_addr;
    logic [XLEN-1:0] bus_wdata;
    logic            bus_done;
    logic [XLEN-1:0] bus_rdata;

    fetch_sequencer #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst(rst),
        .bus_done_i(bus_done), .bus_rdata_i(bus_rdata),
        .alu_result_i(alu_result), .branch_taken_i(branch_taken),
        .imm_i(imm), .rs2_data_i(rs2_data), .opcode_i(opcode), .rd_i(rd),
        .instr_o(instr), .bus_req_o(bus_req), .bus_we_o(bus_we),
        .bus_addr_o(bus_addr), .bus_wdata_o(bus_wdata),
        .rd_we_o(rd_we), .rd_data_o(rd_data)
    );

    decoder u_dec (
        .instr_i(instr), .opcode_o(opcode), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
        .imm_o(imm), .alu_op_o(alu_op), .use_imm_o(use_imm)
    );

    register_file #(.NUM_REGS(NUM_REGS)) u_regs (
        .clk(clk), .rst(rst), .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd),
        .we_i(rd_we), .wd_i(rd_data),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    alu u_alu (
        .op_i(alu_op), .a_i(rs1_data), .b_i(rs2_data), .imm_i(imm), .use_imm_i(use_imm),
        .result_o(alu_result), .branch_taken_o(branch_taken)
    );

    apb_master u_apb (
        .clk(clk), .rst(rst),
        .req_i(bus_req), .we_i(bus_we), .addr_i(bus_addr), .wdata_i(bus_wdata),
        .prdata_i(prdata_i), .pready_i(pready_i),
        .done_o(bus_done), .rdata_o(bus_rdata),
        .paddr_o(paddr_o), .psel_o(psel_o), .penable_o(penable_o),
        .pwrite_o(pwrite_o), .pwdata_o(pwdata_o)
    );

endmodule

// ==== verif/cpu_core_chk.sv ====
`timescale 1ns/1ps

module cpu_core_chk (
    input logic        clk,
    input logic        rst,
    input logic        psel_i,
    input logic        penable_i,
    input logic        pwrite_i,
    input logic        pready_i,
    input logic [31:0] paddr_i,
    input logic [31:0] pwdata_i
);

    // setup is always followed by access
    a_setup_then_access: assert property (@(posedge clk) disable iff (rst)
        (psel_i && !penable_i) |=> (psel_i && penable_i))
        else $error("penable did not follow a setup cycle");

    // held from setup until the completing access cycle
    a_stable_in_transfer: assert property (@(posedge clk) disable iff (rst)
        (psel_i && !(penable_i && pready_i)) |=>
            ($stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i)))
        else $error("apb address or data changed while the transfer waited");

    // no back to back transfers
    a_idle_after_done: assert property (@(posedge clk) disable iff (rst)
        (psel_i && penable_i && pready_i) |=> !psel_i)
        else $error("psel stayed high after a completed transfer");

    a_idle_in_reset: assert property (@(posedge clk) rst |-> (!psel_i && !penable_i))
        else $error("psel high during reset");

endmodule

bind cpu_core cpu_core_chk u_chk (
    .clk(clk), .rst(rst),
    .psel_i(psel_o), .penable_i(penable_o), .pwrite_i(pwrite_o), .pready_i(pready_i),
    .paddr_i(paddr_o), .pwdata_i(pwdata_o)
);

// ==== verif/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb;

    localparam int          CLK_PERIOD = 20;
    localparam int          MEM_WORDS  = 256;
    localparam int          MAX_WAIT   = 3;     // longest pready_i low stretch
    localparam logic [31:0] START_PC   = 32'h0; // matches the default RESET_PC

    logic        clk;
    logic        rst;
    logic [31:0] prdata_i;
    logic        pready_i;
    logic [31:0] paddr_o;
    logic        psel_o;
    logic        penable_o;
    logic        pwrite_o;
    logic [31:0] pwdata_o;

    logic [31:0] mem   [MEM_WORDS];
    logic        known [MEM_WORDS]; // loaded from the stim file or written by the core
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    integer seed = 77411;
    integer errors = 0;
    integer stores_seen = 0;
    integer exp_count = 0;
    integer wait_left = 0;
    logic   stim_loaded = 1'b0;
    logic   first_seen = 1'b0;

    cpu_core UUT (
        .clk(clk), .rst(rst),
        .prdata_i(prdata_i), .pready_i(pready_i),
        .paddr_o(paddr_o), .psel_o(psel_o), .penable_o(penable_o),
        .pwrite_o(pwrite_o), .pwdata_o(pwdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // P lines fill the program memory, S lines queue the expected stores
    task automatic load_stim();
        integer    fd;
        integer    n;
        string     line;
        byte       kind;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen("verif/cpu_core_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the stimulus file verif/cpu_core_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = ""; // a failed read at end of file leaves nothing to scan
                n = $fgets(line, fd);
                n = $sscanf(line, "%c %h %h", kind, a, d);
                if (n == 3 && kind == "P") begin
                    mem[a[9:2]]   = d;
                    known[a[9:2]] = 1'b1;
                end else if (n == 3 && kind == "S") begin
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                end
            end
            $fclose(fd);
            exp_count = exp_addr.size();
        end
    endtask

    function automatic logic in_range(input logic [31:0] addr);
        return (addr < MEM_WORDS * 4) && (addr[1:0] == 2'b00);
    endfunction

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] ea;
        logic [31:0] ed;
        if (exp_addr.size() == 0) begin
            errors++;
            $display("error at %0d ns: extra store to %h data %h", $time, addr, data);
        end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            if (addr != ea || data != ed) begin
                errors++;
                $display("error at %0d ns: store %0d to %h data %h, expected %h data %h",
                         $time, stores_seen, addr, data, ea, ed);
            end
        end
        stores_seen++;
        if (in_range(addr)) begin
            mem[addr[9:2]]   = data;
            known[addr[9:2]] = 1'b1;
        end
    endtask

    // apb completer, random wait states
    always @(posedge clk) begin
        if (rst) begin
            pready_i <= 1'b0;
        end else if (psel_o && !penable_o) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                if (paddr_o != START_PC || pwrite_o) begin
                    errors++;
                    $display("error at %0d ns: first transfer at %h, expected read at %h",
                             $time, paddr_o, START_PC);
                end
            end
            if (!in_range(paddr_o)) begin
                errors++;
                $display("error at %0d ns: transfer outside memory at %h", $time, paddr_o);
            end else if (!pwrite_o && !known[paddr_o[9:2]]) begin
                errors++;
                $display("error at %0d ns: read of unloaded word at %h", $time, paddr_o);
            end
            wait_left = $unsigned($random(seed)) % (MAX_WAIT + 1);
            if (wait_left == 0) begin
                pready_i <= 1'b1;
                prdata_i <= mem[paddr_o[9:2]];
            end
        end else if (psel_o && penable_o) begin
            if (pready_i) begin
                pready_i <= 1'b0;
                if (pwrite_o) check_store(paddr_o, pwdata_o);
            end else begin
                wait_left = wait_left - 1;
                if (wait_left == 0) begin
                    pready_i <= 1'b1;
                    prdata_i <= mem[paddr_o[9:2]];
                end
            end
        end
    end

    initial begin
        rst      = 1'b1;
        prdata_i = '0;
        pready_i = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]   = 32'hbad00000 ^ (i * 32'h00010101); // unloaded words stand out
            known[i] = 1'b0;
        end
        load_stim();
        stim_loaded = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        wait (stores_seen >= exp_count);
        repeat (100) @(posedge clk); // self loop must stay quiet
        $display("stores seen %0d of %0d, errors %0d", stores_seen, exp_count, errors);
        if (errors == 0 && stores_seen == exp_count) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog, scaled by the length of the program
    initial begin
        wait (stim_loaded);
        repeat (10 + exp_count * 40 * 12) @(posedge clk);
        $display("timeout: program never reached its final store");
        $display("stores seen %0d of %0d, errors %0d", stores_seen, exp_count, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verif/cpu_core_stim.txt ====
# P <byte address hex> <instruction word hex>  program image
# S <byte address hex> <data hex>              expected stores, in order
P 00000000 123450B7
P 00000004 FFB00113
P 00000008 10000193
P 0000000C 00208233
P 00000010 0041A023
P 00000014 0F014293
P 00000018 40128333
P 0000001C 0061A223
P 00000020 00411393
P 00000024 0083D413
P 00000028 001464B3
P 0000002C 0064F533
P 00000030 00A1A423
P 00000034 0041A583
P 00000038 0075D633
P 0000003C 00C1A623
P 00000040 00B1A823
P 00000044 00014463
P 00000048 0021AA23
P 0000004C 00015463
P 00000050 0021AA23
P 00000054 00420463
P 00000058 0001AC23
P 0000005C 00421463
P 00000060 0080076F
P 00000064 0001AC23
P 00000068 00E1AC23
P 0000006C 0000006F
S 00000100 12344FFB
S 00000104 EDCBAF0B
S 00000108 00CBAF0B
S 0000010C 0000EDCB
S 00000110 EDCBAF0B
S 00000114 FFFFFFFB
S 00000118 00000064

// ==== cpu_core.f ====
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/decoder.sv
rtl/register_file.sv
rtl/apb_master.sv
rtl/fetch_sequencer.sv
rtl/cpu_core.sv
verif/cpu_core_chk.sv
verif/cpu_core_tb.sv

// ==== Makefile ====
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f cpu_core.f \
		--top-module cpu_core_tb --Mdir $(OBJ_DIR) -o sim

run: compile
	./$(OBJ_DIR)/sim | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
